//--- Makefile
SRCS := $(shell cat spi_wb_top.f)

.PHONY: run clean

run: obj_dir/Vspi_wb_tb
	obj_dir/Vspi_wb_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

obj_dir/Vspi_wb_tb: spi_wb_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module spi_wb_tb -f spi_wb_top.f

clean:
	rm -rf obj_dir sim.log

//--- common/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

    typedef enum logic [1:0] {
        DIR_IDLE = 2'd0,
        DIR_RX   = 2'd1,
        DIR_TX   = 2'd2
    } spi_dir_e;

    // 14 bit queue entry
    typedef struct packed {
        spi_dir_e   dir;
        logic [1:0] rsvd;
        logic       cs_hold;   // keep cs low afterwards
        logic [8:0] len;       // bytes minus one
    } spi_cmd_t;

    typedef struct packed {
        logic        en;
        logic        cpha;
        logic        cpol;
        logic [15:0] div;      // half period is div+1 clocks
    } spi_cfg_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RX,
        ST_TX,
        ST_DUMMY,
        ST_FINISH
    } spi_state_e;

endpackage

`default_nettype wire

//--- common/spi_reg_pkg.sv
`default_nettype none

package spi_reg_pkg;

    typedef enum logic [4:0] {
        REG_CTRL   = 5'h00,
        REG_STATUS = 5'h04,
        REG_RDATA  = 5'h08,
        REG_WDATA  = 5'h0C,
        REG_CMD    = 5'h10
    } spi_reg_e;

    // control word fields
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_RST_BIT  = 1;   // self clearing
    localparam int CTRL_CPHA_BIT = 2;
    localparam int CTRL_CPOL_BIT = 3;
    localparam int CTRL_DIV_LSB  = 16;
    localparam int CTRL_DIV_MSB  = 31;

    // status bits
    localparam int ST_TX_FULL   = 0;
    localparam int ST_TX_EMPTY  = 1;
    localparam int ST_RX_FULL   = 2;
    localparam int ST_RX_EMPTY  = 3;
    localparam int ST_CMD_FULL  = 4;
    localparam int ST_CMD_EMPTY = 5;
    localparam int STATUS_W     = 6;
    localparam logic [STATUS_W-1:0] STATUS_RESET = 6'b101010;

    localparam int WORD_BITS = 32;
    localparam int BUF_BITS  = 256;
    localparam int BUF_CNT_W = $clog2(BUF_BITS) + 1;   // counts 0..BUF_BITS
    localparam int CMD_DEPTH = 8;
    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);

endpackage

`default_nettype wire

//--- common/spi_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_xfer_if import spi_cmd_pkg::*; ();

    spi_cfg_t cfg;
    logic     cmd_valid;
    spi_cmd_t cmd;         // queue head
    logic     tx_bit;
    logic     tx_avail;

    logic     cmd_take;    // pops the head
    logic     tx_pop;
    logic     rx_push;
    logic     rx_bit;

    modport regs (
        output cfg, cmd_valid, cmd, tx_bit, tx_avail,
        input  cmd_take, tx_pop, rx_push, rx_bit
    );

    modport engine (
        input  cfg, cmd_valid, cmd, tx_bit, tx_avail,
        output cmd_take, tx_pop, rx_push, rx_bit
    );

endinterface

`default_nettype wire

//--- rtl/spi_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_wb_top (
    input  logic        clk_i,
    input  logic        arst_n_i,

    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,     // full words only
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,

    output logic        spi_cs_n_o,
    output logic        spi_sck_o,
    output logic        spi_mosi_o,
    input  logic        spi_miso_i
);

    spi_xfer_if u_xfer ();

    spi_regs u_regs (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cyc_i    (wb_cyc_i),
        .stb_i    (wb_stb_i),
        .we_i     (wb_we_i),
        .adr_i    (wb_adr_i),
        .dat_i    (wb_dat_i),
        .dat_o    (wb_dat_o),
        .ack_o    (wb_ack_o),
        .xfer     (u_xfer.regs)
    );

    spi_engine u_engine (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .spi_miso_i (spi_miso_i),
        .spi_cs_n_o (spi_cs_n_o),
        .spi_sck_o  (spi_sck_o),
        .spi_mosi_o (spi_mosi_o),
        .xfer       (u_xfer.engine)
    );

endmodule

`default_nettype wire

//--- spi/spi_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_engine
    import spi_cmd_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       spi_miso_i,
    output logic       spi_cs_n_o,
    output logic       spi_sck_o,
    output logic       spi_mosi_o,
    spi_xfer_if.engine xfer
);

    spi_state_e  state_q;
    logic [15:0] div_cnt_q;
    logic [2:0]  bit_cnt_q;
    logic [8:0]  byte_cnt_q;
    logic [8:0]  len_q;
    logic        cs_hold_q;
    logic        sck_q;         // before cpol
    logic        cs_n_q;
    logic        mosi_q;

    logic        tick;
    logic        lead;
    logic        trail;
    logic        last_bit;
    logic        fin_done;
    logic        start;
    logic        early_bit;
    logic        shift_out;
    logic        sample_in;

    always_comb begin
        tick      = div_cnt_q == xfer.cfg.div;
        lead      = tick && !sck_q;     // first edge of a bit
        trail     = tick && sck_q;
        last_bit  = bit_cnt_q == 3'd7 && byte_cnt_q == len_q;
        fin_done  = state_q == ST_FINISH && tick;
        // a held cs chains straight into the next command
        start     = xfer.cfg.en && xfer.cmd_valid &&
                    (state_q == ST_IDLE || (fin_done && cs_hold_q));
        early_bit = xfer.cmd.dir == DIR_TX && !xfer.cfg.cpha;
        shift_out = xfer.cfg.en && state_q == ST_TX &&
                    (xfer.cfg.cpha ? lead : (trail && !last_bit));
        sample_in = xfer.cfg.en && state_q == ST_RX && (xfer.cfg.cpha ? trail : lead);
    end

    assign xfer.cmd_take = start;
    assign xfer.tx_pop   = xfer.tx_avail && (shift_out || (start && early_bit));
    assign xfer.rx_push  = sample_in;
    assign xfer.rx_bit   = spi_miso_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            div_cnt_q  <= '0;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            len_q      <= '0;
            cs_hold_q  <= 1'b0;
            sck_q      <= 1'b0;
            cs_n_q     <= 1'b1;
            mosi_q     <= 1'b0;
        end else if (!xfer.cfg.en) begin
            state_q <= ST_IDLE;
            sck_q   <= 1'b0;
            cs_n_q  <= 1'b1;
            mosi_q  <= 1'b0;
        end else if (start) begin
            div_cnt_q  <= '0;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            len_q      <= xfer.cmd.len;
            cs_hold_q  <= xfer.cmd.cs_hold;
            sck_q      <= 1'b0;
            cs_n_q     <= 1'b0;
            mosi_q     <= early_bit && xfer.tx_avail && xfer.tx_bit;   // cpha 0 first bit
            case (xfer.cmd.dir)
                DIR_RX:  state_q <= ST_RX;
                DIR_TX:  state_q <= ST_TX;
                default: state_q <= ST_DUMMY;
            endcase
        end else if (state_q != ST_IDLE) begin
            div_cnt_q <= tick ? '0 : div_cnt_q + 16'd1;
            if (state_q == ST_FINISH) begin
                if (fin_done && !cs_hold_q) begin
                    cs_n_q  <= 1'b1;
                    state_q <= ST_IDLE;
                end
            end else if (tick) begin
                sck_q <= !sck_q;
                if (shift_out) begin
                    mosi_q <= xfer.tx_avail && xfer.tx_bit;  // 0 once buffer runs dry
                end
                if (trail) begin
                    bit_cnt_q <= bit_cnt_q + 3'd1;
                    if (bit_cnt_q == 3'd7) begin
                        byte_cnt_q <= byte_cnt_q + 9'd1;
                    end
                    if (last_bit) begin
                        state_q <= ST_FINISH;
                    end
                end
            end
        end
    end

    assign spi_cs_n_o = cs_n_q;
    assign spi_sck_o  = sck_q ^ xfer.cfg.cpol;
    assign spi_mosi_o = mosi_q;

endmodule

`default_nettype wire

//--- spi/spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_regs
    import spi_reg_pkg::*;
    import spi_cmd_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [4:0]  adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    spi_xfer_if.regs    xfer
);

    logic [31:0]          ctrl_q;
    logic                 soft_rst;
    logic                 req;
    logic                 wr;
    logic                 rd;
    logic [STATUS_W-1:0]  status;
    logic [31:0]          rd_data;

    spi_cmd_t             cmd_mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] cmd_wr_ptr_q;
    logic [CMD_PTR_W-1:0] cmd_rd_ptr_q;
    logic [CMD_PTR_W:0]   cmd_cnt_q;
    logic                 cmd_push;
    logic                 cmd_pop;

    logic [BUF_BITS-1:0]  tx_buf_q;
    logic [BUF_BITS-1:0]  tx_buf_n;
    logic [BUF_CNT_W-1:0] tx_cnt_q;
    logic [BUF_CNT_W-1:0] tx_cnt_n;
    logic                 tx_push;
    logic                 tx_pop;

    logic [BUF_BITS-1:0]  rx_buf_q;
    logic [BUF_BITS-1:0]  rx_buf_n;
    logic [BUF_CNT_W-1:0] rx_cnt_q;
    logic [BUF_CNT_W-1:0] rx_cnt_n;
    logic                 rx_pull;

    assign req      = cyc_i && stb_i && !ack_o;
    assign wr       = req && we_i;
    assign rd       = req && !we_i;
    assign soft_rst = ctrl_q[CTRL_RST_BIT];

    // full targets drop the write but still ack
    assign cmd_push = wr && adr_i == REG_CMD && !status[ST_CMD_FULL];
    assign cmd_pop  = xfer.cmd_take && xfer.cmd_valid;
    assign tx_push  = wr && adr_i == REG_WDATA && !status[ST_TX_FULL];
    assign tx_pop   = xfer.tx_pop && xfer.tx_avail;
    assign rx_pull  = rd && adr_i == REG_RDATA && !status[ST_RX_EMPTY];

    always_comb begin
        status[ST_TX_FULL]   = tx_cnt_q > BUF_CNT_W'(BUF_BITS - WORD_BITS);  // no room for a word
        status[ST_TX_EMPTY]  = tx_cnt_q == '0;
        status[ST_RX_FULL]   = rx_cnt_q == BUF_CNT_W'(BUF_BITS);
        status[ST_RX_EMPTY]  = rx_cnt_q == '0;
        status[ST_CMD_FULL]  = cmd_cnt_q == (CMD_PTR_W+1)'(CMD_DEPTH);
        status[ST_CMD_EMPTY] = cmd_cnt_q == '0;
    end

    always_comb begin
        tx_buf_n = tx_buf_q;
        tx_cnt_n = tx_cnt_q;
        if (tx_pop) begin
            tx_buf_n = tx_buf_q >> 1;
            tx_cnt_n = tx_cnt_q - 1'b1;
        end
        if (tx_push) begin
            tx_buf_n[tx_cnt_n[BUF_CNT_W-2:0] +: WORD_BITS] = dat_i;
            tx_cnt_n = tx_cnt_n + BUF_CNT_W'(WORD_BITS);
        end
    end

    always_comb begin
        rx_buf_n = rx_buf_q;
        rx_cnt_n = rx_cnt_q;
        if (rx_pull) begin
            rx_buf_n = rx_buf_q >> WORD_BITS;
            rx_cnt_n = (rx_cnt_q > BUF_CNT_W'(WORD_BITS)) ? rx_cnt_q - BUF_CNT_W'(WORD_BITS) : '0;
        end
        // bit is lost when the buffer is full
        if (xfer.rx_push && rx_cnt_n != BUF_CNT_W'(BUF_BITS)) begin
            rx_buf_n[rx_cnt_n[BUF_CNT_W-2:0]] = xfer.rx_bit;
            rx_cnt_n = rx_cnt_n + 1'b1;
        end
    end

    always_comb begin
        case (adr_i)
            REG_CTRL:   rd_data = ctrl_q;
            REG_STATUS: rd_data = {{(32-STATUS_W){1'b0}}, status};
            // masks off bits past the count, zero when empty
            REG_RDATA:  rd_data = rx_buf_q[WORD_BITS-1:0] & ~({WORD_BITS{1'b1}} << rx_cnt_q);
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q       <= '0;
            cmd_wr_ptr_q <= '0;
            cmd_rd_ptr_q <= '0;
            cmd_cnt_q    <= '0;
            tx_cnt_q     <= '0;
            rx_cnt_q     <= '0;
        end else if (soft_rst) begin
            ctrl_q       <= '0;
            cmd_wr_ptr_q <= '0;
            cmd_rd_ptr_q <= '0;
            cmd_cnt_q    <= '0;
            tx_cnt_q     <= '0;
            rx_cnt_q     <= '0;
        end else begin
            if (wr && adr_i == REG_CTRL) begin
                ctrl_q <= dat_i;
            end
            if (cmd_push) begin
                cmd_wr_ptr_q <= cmd_wr_ptr_q + 1'b1;
            end
            if (cmd_pop) begin
                cmd_rd_ptr_q <= cmd_rd_ptr_q + 1'b1;
            end
            case ({cmd_push, cmd_pop})
                2'b10:   cmd_cnt_q <= cmd_cnt_q + 1'b1;
                2'b01:   cmd_cnt_q <= cmd_cnt_q - 1'b1;
                default: cmd_cnt_q <= cmd_cnt_q;
            endcase
            tx_cnt_q <= tx_cnt_n;
            rx_cnt_q <= rx_cnt_n;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_push) begin
            cmd_mem[cmd_wr_ptr_q] <= spi_cmd_t'(dat_i[$bits(spi_cmd_t)-1:0]);
        end
        tx_buf_q <= tx_buf_n;
        rx_buf_q <= rx_buf_n;
        if (rd) begin
            dat_o <= rd_data;
        end
    end

    assign xfer.cfg = '{
        en:   ctrl_q[CTRL_EN_BIT],
        cpha: ctrl_q[CTRL_CPHA_BIT],
        cpol: ctrl_q[CTRL_CPOL_BIT],
        div:  ctrl_q[CTRL_DIV_MSB:CTRL_DIV_LSB]
    };
    assign xfer.cmd_valid = !status[ST_CMD_EMPTY];
    assign xfer.cmd       = cmd_mem[cmd_rd_ptr_q];
    assign xfer.tx_bit    = tx_buf_q[0];        // lsb first
    assign xfer.tx_avail  = !status[ST_TX_EMPTY];

endmodule

`default_nettype wire

//--- spi_wb_top.f
common/spi_reg_pkg.sv
common/spi_cmd_pkg.sv
common/spi_xfer_if.sv
spi/spi_regs.sv
spi/spi_engine.sv
rtl/spi_wb_top.sv
verification/spi_wb_assert.sv
verification/spi_wb_tb.sv

//--- verification/spi_wb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module spi_wb_assert
    import spi_cmd_pkg::*;
(
    input logic       clk_i,
    input logic       arst_n_i,
    input logic       ack_i,
    input logic       cs_n_i,
    input logic       sck_i,
    input logic       cpol_i,
    input spi_state_e state_i
);

    ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_i |=> !ack_i)
        else $error("wishbone ack high for two cycles");

    cs_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state_i == ST_IDLE |-> cs_n_i)
        else $error("chip select low while the engine is idle");

    // clock parks at its idle level between transfers
    sck_park: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cs_n_i |-> sck_i == cpol_i)
        else $error("sck off its idle level while chip select is high");

endmodule

bind spi_wb_top spi_wb_assert u_assert (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ack_i    (wb_ack_o),
    .cs_n_i   (spi_cs_n_o),
    .sck_i    (spi_sck_o),
    .cpol_i   (u_regs.ctrl_q[spi_reg_pkg::CTRL_CPOL_BIT]),
    .state_i  (u_engine.state_q)
);

`default_nettype wire

//--- verification/spi_wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_wb_tb
    import spi_reg_pkg::*;
    import spi_cmd_pkg::*;
();

    localparam int DIV = 1;                       // half period of 2 clocks
    localparam logic [31:0] SEED = 32'hf7278283;
    localparam logic [31:0] STATUS_IDLE = (32'd1 << ST_TX_EMPTY) | (32'd1 << ST_RX_EMPTY) |
                                          (32'd1 << ST_CMD_EMPTY);
    // half periods of every queued command, including the dropped ninth one
    localparam int HALVES = 4 * (16 * 8 + 1) + (16 * 4 + 1) + 9 * (16 * 1 + 1) +
                            2 * (16 * 2 + 1) + (16 * 8 + 1);
    localparam int MAX_CYCLES = 5 * HALVES * (DIV + 1);

    logic        clk_i;
    logic        arst_n_i;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic [3:0]  wb_sel;
    logic        wb_ack;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;

    int          error_cnt;
    int          check_cnt;
    int          cycle_cnt;
    logic        cpol;
    logic        cpha;
    logic [31:0] rng_q;          // stimulus generator
    logic [31:0] miso_lfsr;
    logic        miso_next;
    logic        cs_prev;
    logic        sck_prev;
    int          fall_cnt;
    int          rise_cnt;
    int          lead_cnt;
    logic [63:0] mosi_cap;
    int          mosi_cnt;
    logic [31:0] rd_val;

    spi_wb_top u_spi_wb_top (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_sel_i   (wb_sel),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack),
        .spi_cs_n_o (spi_cs_n),
        .spi_sck_o  (spi_sck),
        .spi_mosi_o (spi_mosi),
        .spi_miso_i (spi_miso)
    );

    always #50 clk_i = ~clk_i;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // word n of the slave pattern, first bit in bit 0
    function automatic logic [31:0] spi_expect_rx(input int word_idx);
        logic [31:0] s;
        logic [31:0] w;
        s = SEED;
        w = '0;
        for (int i = 0; i < 32 * (word_idx + 1); i++) begin
            s = lfsr_step(s);
            if (i >= 32 * word_idx) begin
                w[i - 32 * word_idx] = s[0];
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic en, input logic pol, input logic pha);
        return (32'(DIV) << CTRL_DIV_LSB) | (32'(pol) << CTRL_CPOL_BIT) |
               (32'(pha) << CTRL_CPHA_BIT) | (32'(en) << CTRL_EN_BIT);
    endfunction

    function automatic logic [31:0] cmd_word(input spi_dir_e dir, input logic hold,
                                             input logic [8:0] len);
        return {18'd0, dir, 2'b00, hold, len};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            rng_q = lfsr_step(rng_q);
            w[i] = rng_q[0];
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic finish_access(output logic [31:0] data);
        int   n;
        logic got;
        n = 0;
        got = 1'b0;
        data = '0;
        while (!got && n < 4) begin
            @(negedge clk_i);
            n++;
            if (wb_ack) begin
                got = 1'b1;
                data = wb_dat_r;
            end
        end
        if (!got) begin
            error_cnt++;
            $display("bus access to 0x%02h at %0t got no ack within 4 cycles", wb_adr, $time);
        end
        @(posedge clk_i);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input spi_reg_e addr, input logic [31:0] data);
        logic [31:0] ignored;
        @(posedge clk_i);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        finish_access(ignored);
    endtask

    task automatic wb_read(input spi_reg_e addr, output logic [31:0] data);
        @(posedge clk_i);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        finish_access(data);
    endtask

    // queue drained, then the last command releases cs
    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[ST_CMD_EMPTY]) begin
            wb_read(REG_STATUS, st);
        end
        @(negedge clk_i);
        while (!spi_cs_n) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
    endtask

    // slave model, sampled mid cycle
    always @(negedge clk_i) begin
        if (cs_prev && !spi_cs_n) begin
            fall_cnt++;
            mosi_cnt = 0;
            miso_lfsr = SEED;
            if (!cpha) begin
                miso_lfsr = lfsr_step(miso_lfsr);   // first bit ready before the first edge
                miso_next = miso_lfsr[0];
            end
        end else if (!spi_cs_n && spi_sck != sck_prev) begin
            if (spi_sck != cpol) begin
                lead_cnt++;
            end
            if ((spi_sck != cpol) == !cpha) begin
                if (mosi_cnt < 64) begin
                    mosi_cap[mosi_cnt] = spi_mosi;
                end
                mosi_cnt++;
            end else begin
                miso_lfsr = lfsr_step(miso_lfsr);
                miso_next = miso_lfsr[0];
            end
        end
        if (!cs_prev && spi_cs_n) begin
            rise_cnt++;
        end
        cs_prev = spi_cs_n;
        sck_prev = spi_sck;
    end

    always @(posedge clk_i) begin
        spi_miso <= miso_next;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] w0;
        logic [31:0] w1;
        int          base_fall;
        int          base_rise;
        int          base_lead;
        clk_i = 1'b0;
        arst_n_i = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = 4'hf;
        spi_miso = 1'b0;
        error_cnt = 0;
        check_cnt = 0;
        cycle_cnt = 0;
        cpol = 1'b0;
        cpha = 1'b0;
        rng_q = SEED;
        miso_lfsr = SEED;
        miso_next = 1'b0;
        cs_prev = 1'b1;
        sck_prev = 1'b0;
        fall_cnt = 0;
        rise_cnt = 0;
        lead_cnt = 0;
        mosi_cap = '0;
        mosi_cnt = 0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;

        wb_read(REG_STATUS, rd_val);
        check_val("status after reset", rd_val, STATUS_IDLE);
        wb_read(REG_CTRL, rd_val);
        check_val("ctrl after reset", rd_val, 32'd0);

        // transmit in all four modes
        for (int m = 0; m < 4; m++) begin
            cpol = m[1];
            cpha = m[0];
            wb_write(REG_CTRL, ctrl_word(1'b1, cpol, cpha));
            rand_word(w0);
            rand_word(w1);
            wb_write(REG_WDATA, w0);
            wb_write(REG_WDATA, w1);
            wb_write(REG_CMD, cmd_word(DIR_TX, 1'b0, 9'd7));
            wait_done();
            check_val("mosi word 0", mosi_cap[31:0], w0);
            check_val("mosi word 1", mosi_cap[63:32], w1);
            check_val("mosi bit count", 32'(mosi_cnt), 32'd64);
        end

        cpol = 1'b0;
        cpha = 1'b0;
        wb_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
        wb_write(REG_CMD, cmd_word(DIR_RX, 1'b0, 9'd3));
        wait_done();
        wb_read(REG_RDATA, rd_val);
        check_val("rdata", rd_val, spi_expect_rx(0));
        wb_read(REG_RDATA, rd_val);
        check_val("rdata when empty", rd_val, 32'd0);
        wb_read(REG_STATUS, rd_val);
        check_val("status rx_empty", 32'(rd_val[ST_RX_EMPTY]), 32'd1);

        // ninth command is dropped
        wb_write(REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0));
        for (int i = 0; i < 9; i++) begin
            wb_write(REG_CMD, cmd_word(DIR_IDLE, 1'b0, 9'd0));
        end
        wb_read(REG_STATUS, rd_val);
        check_val("status cmd_full", 32'(rd_val[ST_CMD_FULL]), 32'd1);
        base_fall = fall_cnt;
        wb_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
        wait_done();
        check_val("transfers from full queue", 32'(fall_cnt - base_fall), 32'd8);
        wb_read(REG_STATUS, rd_val);
        check_val("status cmd_empty", 32'(rd_val[ST_CMD_EMPTY]), 32'd1);

        wb_write(REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0));
        wb_write(REG_CMD, cmd_word(DIR_IDLE, 1'b1, 9'd1));
        wb_write(REG_CMD, cmd_word(DIR_IDLE, 1'b0, 9'd1));
        base_fall = fall_cnt;
        base_rise = rise_cnt;
        base_lead = lead_cnt;
        wb_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
        wait_done();
        check_val("cs falls over held pair", 32'(fall_cnt - base_fall), 32'd1);
        check_val("cs rises over held pair", 32'(rise_cnt - base_rise), 32'd1);
        check_val("sck edges over held pair", 32'(lead_cnt - base_lead), 32'd32);

        // soft reset in the middle of a transfer
        wb_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
        rand_word(w0);
        wb_write(REG_WDATA, w0);
        wb_write(REG_CMD, cmd_word(DIR_TX, 1'b0, 9'd7));
        while (spi_cs_n) begin
            @(negedge clk_i);
        end
        repeat (20) @(posedge clk_i);
        wb_write(REG_CTRL, 32'd1 << CTRL_RST_BIT);
        wb_read(REG_CTRL, rd_val);
        check_val("ctrl after soft reset", rd_val, 32'd0);
        wb_read(REG_STATUS, rd_val);
        check_val("status after soft reset", rd_val, STATUS_IDLE);
        @(negedge clk_i);
        check_val("cs_n after soft reset", 32'(spi_cs_n), 32'd1);

        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
